// ==== include/dmem_defs.svh ====
`ifndef DMEM_DEFS_SVH
`define DMEM_DEFS_SVH

// Data word and address width
`define DMEM_XLEN 32

// One strobe bit per byte lane
`define DMEM_STRB_W 4

// Data BRAM size
`define DMEM_DEPTH_WORDS 1024
`define DMEM_AW 10

// Debug UART receive buffer depth in bytes
`define DBG_FIFO_DEPTH 16

// Debug command bytes
`define DBG_CMD_WRITE 8'h57
`define DBG_CMD_READ 8'h52

// Sent back once a debug write has landed
`define DBG_ACK 8'h06

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data-memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -f sim.f --top-module tb_dmem_subsys -o tb_dmem_subsys

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/tb_dmem_subsys

// ==== sim.f ====
+incdir+include
src/dmem_pkg.sv
src/dmem_bus_if.sv
src/dbg_rx_fifo.sv
src/dbg_bridge.sv
src/dmem_router.sv
src/dmem_bram.sv
src/dmem_subsys_top.sv
verif/tb_dmem_subsys.sv

// ==== src/dbg_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_defs.svh"

module dbg_bridge
  import dmem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx_valid,
  input  logic [7:0] rx_data,
  output logic       rx_ready,
  output logic       tx_valid,
  output logic [7:0] tx_data,
  input  logic       tx_ready,
  output logic       core_stall,
  dmem_bus_if.requester mem
);

  dbg_state_e state;

  logic                  is_write;
  logic [1:0]            byte_cnt;
  logic [2:0]            tx_cnt;
  logic                  rd_load;
  logic [15:0]           idx;
  logic [`DMEM_XLEN-1:0] wdata;
  logic [`DMEM_XLEN-1:0] tx_shift;
  logic [`DMEM_XLEN-1:0] byte_addr;
  logic                  rx_pop;
  logic                  tx_fire;

  // Only take bytes while a command is still being assembled
  assign rx_ready = (state == DBG_IDLE) || (state == DBG_ADDR) || (state == DBG_DATA);
  assign rx_pop   = rx_valid && rx_ready;

  assign tx_valid = (state == DBG_REPLY) && !rd_load;
  assign tx_data  = tx_shift[`DMEM_XLEN-1 -: 8];
  assign tx_fire  = tx_valid && tx_ready;

  // Word index scaled to a byte address below the I/O window
  assign byte_addr = {{(`DMEM_XLEN - 18){1'b0}}, idx, 2'b00};

  assign mem.ren   = (state == DBG_ACCESS) && !is_write;
  assign mem.raddr = byte_addr;
  assign mem.wen   = (state == DBG_ACCESS) && is_write;
  assign mem.waddr = byte_addr;
  assign mem.wdata = wdata;
  assign mem.wstrb = {`DMEM_STRB_W{1'b1}};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= DBG_IDLE;
      is_write   <= 1'b0;
      byte_cnt   <= '0;
      tx_cnt     <= '0;
      rd_load    <= 1'b0;
      core_stall <= 1'b0;
    end else begin
      case (state)
        DBG_IDLE: begin
          // Unknown command bytes are dropped here
          if (rx_pop && (rx_data == `DBG_CMD_WRITE || rx_data == `DBG_CMD_READ)) begin
            is_write   <= (rx_data == `DBG_CMD_WRITE);
            byte_cnt   <= '0;
            core_stall <= 1'b1;
            state      <= DBG_ADDR;
          end
        end
        DBG_ADDR: begin
          if (rx_pop) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd1) begin
              byte_cnt <= '0;
              state    <= is_write ? DBG_DATA : DBG_ACCESS;
            end
          end
        end
        DBG_DATA: begin
          if (rx_pop) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) begin
              state <= DBG_ACCESS;
            end
          end
        end
        DBG_ACCESS: begin
          state   <= DBG_REPLY;
          tx_cnt  <= is_write ? 3'd1 : 3'd4;
          rd_load <= !is_write;
        end
        DBG_REPLY: begin
          if (rd_load) begin
            rd_load <= 1'b0;
          end else if (tx_fire) begin
            tx_cnt <= tx_cnt - 1'b1;
            if (tx_cnt == 3'd1) begin
              core_stall <= 1'b0;
              state      <= DBG_IDLE;
            end
          end
        end
        default: state <= DBG_IDLE;
      endcase
    end
  end

  // Command payload and reply shifter both run most significant byte first
  always_ff @(posedge clk) begin
    if (rx_pop && state == DBG_ADDR) begin
      idx <= {idx[7:0], rx_data};
    end
    if (rx_pop && state == DBG_DATA) begin
      wdata <= {wdata[`DMEM_XLEN-9:0], rx_data};
    end
    if (state == DBG_ACCESS && is_write) begin
      tx_shift <= {`DBG_ACK, {(`DMEM_XLEN - 8){1'b0}}};
    end else if (state == DBG_REPLY && rd_load) begin
      tx_shift <= mem.rdata;
    end else if (tx_fire) begin
      tx_shift <= {tx_shift[`DMEM_XLEN-9:0], 8'h00};
    end
  end

endmodule

`default_nettype wire

// ==== src/dbg_rx_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_defs.svh"

module dbg_rx_fifo (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr_valid,
  input  logic [7:0] wr_data,
  output logic       wr_ready,
  output logic       rd_valid,
  output logic [7:0] rd_data,
  input  logic       rd_ready
);

  localparam int PTR_W = $clog2(`DBG_FIFO_DEPTH);

  logic [7:0]     buf_mem [`DBG_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_wr;
  logic             do_rd;

  assign wr_ready = (count != `DBG_FIFO_DEPTH);
  assign rd_valid = (count != 0);
  assign rd_data  = buf_mem[rd_ptr];

  assign do_wr = wr_valid && wr_ready;
  assign do_rd = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      buf_mem[wr_ptr] <= wr_data;
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/dmem_bram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_defs.svh"

module dmem_bram
  import dmem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  dmem_bus_if.memory bus
);

  logic [`DMEM_XLEN-1:0] mem [`DMEM_DEPTH_WORDS];
  dmem_addr_u            ra;
  dmem_addr_u            wa;
  logic [`DMEM_AW-1:0]   ridx;
  logic [`DMEM_AW-1:0]   widx;

  assign ra.raw = bus.raddr;
  assign wa.raw = bus.waddr;
  assign ridx   = ra.f.word_idx[`DMEM_AW-1:0];
  assign widx   = wa.f.word_idx[`DMEM_AW-1:0];

  // Byte lanes are written only where the strobe is set
  always_ff @(posedge clk) begin
    if (bus.wen) begin
      for (int i = 0; i < `DMEM_STRB_W; i++) begin
        if (bus.wstrb[i]) begin
          mem[widx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus.rdata <= '0;
    end else if (bus.ren) begin
      bus.rdata <= mem[ridx];
    end
  end

endmodule

`default_nettype wire

// ==== src/dmem_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_defs.svh"

// One memory port with separate read and write request channels
interface dmem_bus_if;

  logic                    ren;
  logic [`DMEM_XLEN-1:0]   raddr;
  logic                    wen;
  logic [`DMEM_XLEN-1:0]   waddr;
  logic [`DMEM_XLEN-1:0]   wdata;
  logic [`DMEM_STRB_W-1:0] wstrb;
  logic [`DMEM_XLEN-1:0]   rdata;

  modport requester (
    output ren, raddr, wen, waddr, wdata, wstrb,
    input  rdata
  );

  modport memory (
    input  ren, raddr, wen, waddr, wdata, wstrb,
    output rdata
  );

endinterface

`default_nettype wire

// ==== src/dmem_pkg.sv ====
`default_nettype none

`include "dmem_defs.svh"

package dmem_pkg;

  // Bit 31 picks I/O space and the rest indexes words in data memory
  typedef struct packed {
    logic                  io_sel;
    logic [`DMEM_XLEN-4:0] word_idx;
    logic [1:0]            byte_off;
  } dmem_addr_t;

  typedef union packed {
    logic [`DMEM_XLEN-1:0] raw;
    dmem_addr_t            f;
  } dmem_addr_u;

  typedef enum logic [2:0] {
    DBG_IDLE,
    DBG_ADDR,
    DBG_DATA,
    DBG_ACCESS,
    DBG_REPLY
  } dbg_state_e;

endpackage

`default_nettype wire

// ==== src/dmem_router.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_defs.svh"

module dmem_router
  import dmem_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    core_stall,
  input  logic                    core_ren,
  input  logic [`DMEM_XLEN-1:0]   core_raddr,
  input  logic                    core_wen,
  input  logic [`DMEM_XLEN-1:0]   core_waddr,
  input  logic [`DMEM_XLEN-1:0]   core_wdata,
  input  logic [`DMEM_STRB_W-1:0] core_wstrb,
  output logic [`DMEM_XLEN-1:0]   core_rdata,
  output logic                    io_ren,
  output logic [`DMEM_XLEN-1:0]   io_raddr,
  output logic                    io_wen,
  output logic [`DMEM_XLEN-1:0]   io_waddr,
  output logic [`DMEM_XLEN-1:0]   io_wdata,
  output logic [`DMEM_STRB_W-1:0] io_wstrb,
  input  logic [`DMEM_XLEN-1:0]   io_rdata,
  dmem_bus_if.memory              dbg,
  dmem_bus_if.requester           ram
);

  dmem_addr_u core_ra;
  dmem_addr_u core_wa;
  logic       core_rd;
  logic       core_wr;
  logic       io_sel_q;

  assign core_ra = core_raddr;
  assign core_wa = core_waddr;

  // The core is shut out while the debug bridge owns memory
  assign core_rd = core_ren && !core_stall;
  assign core_wr = core_wen && !core_stall;

  assign io_ren   = core_rd && core_ra.f.io_sel;
  assign io_raddr = core_ra.raw;
  assign io_wen   = core_wr && core_wa.f.io_sel;
  assign io_waddr = core_wa.raw;
  assign io_wdata = core_wdata;
  assign io_wstrb = core_wstrb;

  assign ram.ren   = core_stall ? dbg.ren : (core_rd && !core_ra.f.io_sel);
  assign ram.raddr = core_stall ? dbg.raddr : core_ra.raw;
  assign ram.wen   = core_stall ? dbg.wen : (core_wr && !core_wa.f.io_sel);
  assign ram.waddr = core_stall ? dbg.waddr : core_wa.raw;
  assign ram.wdata = core_stall ? dbg.wdata : core_wdata;
  assign ram.wstrb = core_stall ? dbg.wstrb : core_wstrb;

  // Target of the last accepted core read steers the data return mux
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      io_sel_q <= 1'b0;
    end else if (core_rd) begin
      io_sel_q <= core_ra.f.io_sel;
    end
  end

  assign core_rdata = io_sel_q ? io_rdata : ram.rdata;
  assign dbg.rdata  = ram.rdata;

endmodule

`default_nettype wire

// ==== src/dmem_subsys_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_defs.svh"

module dmem_subsys_top (
  input  logic                    clk,
  input  logic                    rst_n,

  // Core data port
  input  logic                    dmem_ren,
  input  logic [`DMEM_XLEN-1:0]   dmem_raddr,
  input  logic                    dmem_wen,
  input  logic [`DMEM_XLEN-1:0]   dmem_waddr,
  input  logic [`DMEM_XLEN-1:0]   dmem_wdata,
  input  logic [`DMEM_STRB_W-1:0] dmem_wstrb,
  output logic [`DMEM_XLEN-1:0]   dmem_rdata,
  output logic                    core_stall,

  // Memory-mapped I/O
  output logic                    io_ren,
  output logic [`DMEM_XLEN-1:0]   io_raddr,
  output logic                    io_wen,
  output logic [`DMEM_XLEN-1:0]   io_waddr,
  output logic [`DMEM_XLEN-1:0]   io_wdata,
  output logic [`DMEM_STRB_W-1:0] io_wstrb,
  input  logic [`DMEM_XLEN-1:0]   io_rdata,

  // Debug UART byte streams
  input  logic                    urx_valid,
  input  logic [7:0]              urx_data,
  output logic                    urx_ready,
  output logic                    utx_valid,
  output logic [7:0]              utx_data,
  input  logic                    utx_ready
);

  logic       fifo_valid;
  logic [7:0] fifo_data;
  logic       fifo_ready;

  dmem_bus_if dbg_bus ();
  dmem_bus_if ram_bus ();

  dbg_rx_fifo u_rx_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (urx_valid),
    .wr_data  (urx_data),
    .wr_ready (urx_ready),
    .rd_valid (fifo_valid),
    .rd_data  (fifo_data),
    .rd_ready (fifo_ready)
  );

  dbg_bridge u_bridge (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_valid   (fifo_valid),
    .rx_data    (fifo_data),
    .rx_ready   (fifo_ready),
    .tx_valid   (utx_valid),
    .tx_data    (utx_data),
    .tx_ready   (utx_ready),
    .core_stall (core_stall),
    .mem        (dbg_bus.requester)
  );

  dmem_router u_router (
    .clk        (clk),
    .rst_n      (rst_n),
    .core_stall (core_stall),
    .core_ren   (dmem_ren),
    .core_raddr (dmem_raddr),
    .core_wen   (dmem_wen),
    .core_waddr (dmem_waddr),
    .core_wdata (dmem_wdata),
    .core_wstrb (dmem_wstrb),
    .core_rdata (dmem_rdata),
    .io_ren     (io_ren),
    .io_raddr   (io_raddr),
    .io_wen     (io_wen),
    .io_waddr   (io_waddr),
    .io_wdata   (io_wdata),
    .io_wstrb   (io_wstrb),
    .io_rdata   (io_rdata),
    .dbg        (dbg_bus.memory),
    .ram        (ram_bus.requester)
  );

  dmem_bram u_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (ram_bus.memory)
  );

endmodule

`default_nettype wire

// ==== verif/dmem_stimulus.txt ====
# port op addr data strb expected  (C core to BRAM, I core to I/O, D debug with word index)
# ops W write, R read, U unknown debug command byte taken from data; expected is hex
C W 00000010 11223344 f 00000000
C W 00000010 aabbccdd 5 00000000
C R 00000010 00000000 0 11bb33dd
I R 80000040 00000000 0 25a5f04f
I W 80000010 deadbeef 6 00000000
C R 00000010 00000000 0 11bb33dd
I R 8000abc4 00000000 0 25a55bcb
D W 00000020 cafef00d 0 00000006
C R 00000080 00000000 0 cafef00d
D W 000003ff 89abcdef 0 00000006
C R 00000ffc 00000000 0 89abcdef
C W 00000100 01020304 f 00000000
D R 00000040 00000000 0 01020304
D R 00000040 00000000 0 01020304
D U 00000000 000000a5 0 00000000
D R 00000004 00000000 0 11bb33dd
C W 00000080 00005500 2 00000000
C R 00000080 00000000 0 cafe550d
D R 00000020 00000000 0 cafe550d
I R 80000000 00000000 0 25a5f00f

// ==== verif/tb_dmem_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_defs.svh"

module tb_dmem_subsys;

  localparam int          WAIT_LIMIT = 200;
  localparam logic [31:0] IO_KEY     = 32'ha5a5_f00f;

  logic        clk;
  logic        rst_n;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic        dmem_wen;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic [31:0] dmem_rdata;
  logic        core_stall;
  logic        io_ren;
  logic [31:0] io_raddr;
  logic        io_wen;
  logic [31:0] io_waddr;
  logic [31:0] io_wdata;
  logic [3:0]  io_wstrb;
  logic [31:0] io_rdata;
  logic        urx_valid;
  logic [7:0]  urx_data;
  logic        urx_ready;
  logic        utx_valid;
  logic [7:0]  utx_data;
  logic        utx_ready;

  logic [31:0] io_resp = '0;

  // Stimulus line fields
  string       line;
  int          fd;
  int          nfields;
  int          nlines;
  logic [7:0]  port_c;
  logic [7:0]  op_c;
  logic [31:0] addr;
  logic [31:0] data;
  logic [3:0]  strb;
  logic [31:0] exp;

  dmem_subsys_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_wen   (dmem_wen),
    .dmem_waddr (dmem_waddr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_rdata (dmem_rdata),
    .core_stall (core_stall),
    .io_ren     (io_ren),
    .io_raddr   (io_raddr),
    .io_wen     (io_wen),
    .io_waddr   (io_waddr),
    .io_wdata   (io_wdata),
    .io_wstrb   (io_wstrb),
    .io_rdata   (io_rdata),
    .urx_valid  (urx_valid),
    .urx_data   (urx_data),
    .urx_ready  (urx_ready),
    .utx_valid  (utx_valid),
    .utx_data   (utx_data),
    .utx_ready  (utx_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // I/O device answers one cycle after the read with a scrambled address
  always @(posedge clk) begin
    if (io_ren) begin
      io_resp <= io_raddr ^ IO_KEY;
    end
  end
  assign io_rdata = io_resp;

  // Random back-pressure on the reply stream
  initial begin
    utx_ready = 1'b0;
    void'($urandom(48734));
    forever begin
      @(posedge clk);
      #2;
      utx_ready = ($urandom % 2) == 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, want);
      $display("TB FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic send_byte(input logic [7:0] b);
    int waited;
    waited    = 0;
    urx_valid = 1'b1;
    urx_data  = b;
    @(negedge clk);
    while (!urx_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Timeout: debug receive FIFO never accepted a byte");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    urx_valid = 1'b0;
  endtask

  task automatic recv_byte(output logic [7:0] b);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(utx_valid && utx_ready)) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Timeout: no reply byte arrived from the debug bridge");
      end
      @(negedge clk);
    end
    b = utx_data;
    check_value("core_stall", {31'b0, core_stall}, 32'd1);
    @(posedge clk);
    #2;
  endtask

  task automatic core_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    dmem_wen   = 1'b1;
    dmem_waddr = a;
    dmem_wdata = d;
    dmem_wstrb = s;
    @(negedge clk);
    check_value("io_wen", {31'b0, io_wen}, {31'b0, a[31]});
    if (a[31]) begin
      check_value("io_waddr", io_waddr, a);
      check_value("io_wdata", io_wdata, d);
      check_value("io_wstrb", {28'b0, io_wstrb}, {28'b0, s});
    end
    @(posedge clk);
    #2;
    dmem_wen = 1'b0;
  endtask

  task automatic core_read(input logic [31:0] a, input logic [31:0] want);
    dmem_ren   = 1'b1;
    dmem_raddr = a;
    @(negedge clk);
    check_value("io_ren", {31'b0, io_ren}, {31'b0, a[31]});
    if (a[31]) begin
      check_value("io_raddr", io_raddr, a);
    end
    @(posedge clk);
    #2;
    dmem_ren = 1'b0;
    // Data belongs to the cycle right after the accepting edge
    @(negedge clk);
    check_value("dmem_rdata", dmem_rdata, want);
    @(posedge clk);
    #2;
  endtask

  task automatic debug_write(input logic [15:0] idx, input logic [31:0] d,
                             input logic [7:0] ack);
    logic [7:0] b;
    send_byte(`DBG_CMD_WRITE);
    send_byte(idx[15:8]);
    send_byte(idx[7:0]);
    for (int i = 3; i >= 0; i--) begin
      send_byte(d[i*8 +: 8]);
    end
    recv_byte(b);
    check_value("utx_data ack", {24'b0, b}, {24'b0, ack});
    @(negedge clk);
    check_value("core_stall", {31'b0, core_stall}, 32'd0);
    @(posedge clk);
    #2;
  endtask

  task automatic debug_read(input logic [15:0] idx, input logic [31:0] want);
    logic [7:0]  b;
    logic [31:0] word;
    word = '0;
    send_byte(`DBG_CMD_READ);
    send_byte(idx[15:8]);
    send_byte(idx[7:0]);
    // Core tries to clobber the same word while the bridge owns memory
    dmem_wen   = 1'b1;
    dmem_waddr = {14'b0, idx, 2'b00};
    dmem_wdata = ~want;
    dmem_wstrb = 4'hf;
    @(negedge clk);
    check_value("core_stall", {31'b0, core_stall}, 32'd1);
    @(posedge clk);
    #2;
    dmem_wen = 1'b0;
    for (int i = 0; i < 4; i++) begin
      recv_byte(b);
      word = {word[23:0], b};
    end
    check_value("debug read word", word, want);
    @(negedge clk);
    check_value("core_stall", {31'b0, core_stall}, 32'd0);
    @(posedge clk);
    #2;
  endtask

  task automatic unknown_command(input logic [7:0] b);
    send_byte(b);
    // The bridge must neither stall nor reply in this window
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_value("utx_valid", {31'b0, utx_valid}, 32'd0);
      check_value("core_stall", {31'b0, core_stall}, 32'd0);
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    dmem_ren   = 1'b0;
    dmem_raddr = '0;
    dmem_wen   = 1'b0;
    dmem_waddr = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    urx_valid  = 1'b0;
    urx_data   = '0;
    nlines     = 0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("core_stall", {31'b0, core_stall}, 32'd0);
    check_value("utx_valid", {31'b0, utx_valid}, 32'd0);
    check_value("io_ren", {31'b0, io_ren}, 32'd0);
    check_value("io_wen", {31'b0, io_wen}, 32'd0);
    check_value("urx_ready", {31'b0, urx_ready}, 32'd1);
    @(posedge clk);
    #2;

    fd = $fopen("verif/dmem_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file verif/dmem_stimulus.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      nfields = $sscanf(line, "%c %c %h %h %h %h", port_c, op_c, addr, data, strb, exp);
      if (nfields != 6) begin
        abort_run("A stimulus line does not have six fields");
      end
      nlines++;
      case ({port_c, op_c})
        "CW", "IW": core_write(addr, data, strb);
        "CR", "IR": core_read(addr, exp);
        "DW":       debug_write(addr[15:0], data, exp[7:0]);
        "DR":       debug_read(addr[15:0], exp);
        "DU":       unknown_command(data[7:0]);
        default:    abort_run("A stimulus line has an unknown port or operation");
      endcase
    end
    $fclose(fd);
    if (nlines == 0) begin
      abort_run("The stimulus file holds no operations");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
